// ==== include/rx_parser_defs.svh ====
// rx parser constants for stream widths, header word positions and length limits
`ifndef RX_PARSER_DEFS_SVH
`define RX_PARSER_DEFS_SVH

// stream widths
`define RXP_DATA_W      32
`define RXP_MOD_W       2
`define RXP_CNT_W       16
`define RXP_LEN_W       16
`define RXP_STAT_W      64

// word index of the untagged ethertype, counted from sop (preamble is words 0,1)
`define RXP_TYPE_WORD   5

// max stacked vlan tags skipped
`define RXP_MAX_VLAN    2

// header lengths in 32-bit words
`define RXP_IPV4_WORDS  5
`define RXP_UDP_WORDS   2
`define RXP_TCP_WORDS   5

// frame length limits in bytes
`define RXP_RUNT_LEN    64
`define RXP_JUMBO_LEN   1518

`endif

// ==== rtl/rx_parser_pkg.sv ====
// rx parser types for walker states, ethertypes, ip protocols, layer tags and stat bits
`default_nettype none

package rx_parser_pkg;

  typedef enum logic [2:0] {
    ST_PRE,      // preamble + sfd
    ST_MAC,
    ST_VLAN,
    ST_IPV4,
    ST_UDP,
    ST_TCP,
    ST_PAYLOAD
  } hdr_state_e;

  typedef enum logic [15:0] {
    ET_IPV4   = 16'h0800,
    ET_ARP    = 16'h0806,
    ET_PAUSE  = 16'h8808,
    ET_VLAN_1 = 16'h8100,  // 802.1q
    ET_VLAN_2 = 16'h88a8,  // 802.1ad
    ET_VLAN_3 = 16'h9100
  } eth_type_e;

  typedef enum logic [7:0] {
    IP_TCP = 8'd6,
    IP_UDP = 8'd17
  } ip_proto_e;

  // one-hot or zero, mac is bit 0
  typedef struct packed {
    logic l4;
    logic ipv4;
    logic vlan;
    logic mac;
  } layer_tag_t;

  typedef enum logic [5:0] {
    SB_BCAST = 6'd0,
    SB_MCAST = 6'd1,
    SB_UCAST = 6'd2,
    SB_KEEPALIVE = 6'd3,
    SB_ARP = 6'd8,
    SB_PAUSE = 6'd9,
    SB_VLAN1 = 6'd16,
    SB_VLAN2 = 6'd17,
    SB_IPV4 = 6'd32,
    SB_TCP = 6'd40,
    SB_UDP = 6'd41,
    SB_ANY = 6'd56,
    SB_RUNT = 6'd57,
    SB_JUMBO = 6'd58
  } stat_bit_e;

endpackage

`default_nettype wire

// ==== rtl/rx_word_if.sv ====
// delayed rx word stream with its header layer tag
`default_nettype none
`include "rx_parser_defs.svh"

interface rx_word_if;

  logic [`RXP_DATA_W-1:0]    data;
  logic                      valid;
  logic                      sop;   // qualified by valid
  logic                      eop;   // qualified by valid
  rx_parser_pkg::layer_tag_t tag;

  modport src (
    output data, valid, sop, eop, tag
  );

  modport snk (
    input data, valid, sop, eop, tag
  );

endinterface

`default_nettype wire

// ==== rtl/rx_header_walker.sv ====
// rx header walker, delays the stream two stages and tags each word with its header layer
`default_nettype none
`include "rx_parser_defs.svh"

module rx_header_walker (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     par_en,
  input  wire [`RXP_DATA_W-1:0]   int_data,
  input  wire                     int_valid,
  input  wire                     int_sop,
  input  wire                     int_eop,
  input  wire [`RXP_MOD_W-1:0]    int_mod,
  rx_word_if.src                  wrd,
  output logic [`RXP_MOD_W-1:0]   mod_d,
  output logic [`RXP_DATA_W-1:0]  out_data,
  output logic                    out_valid,
  output logic                    out_sop,
  output logic                    out_eop,
  output logic [`RXP_MOD_W-1:0]   out_mod,
  output logic [`RXP_DATA_W-1:0]  out_info
);

  rx_parser_pkg::hdr_state_e  state_q, state_nxt, cur_state, l3_state;
  rx_parser_pkg::ip_proto_e   proto_q, proto_nxt;
  rx_parser_pkg::layer_tag_t  tag, tag_d1;
  logic [`RXP_CNT_W-1:0]      cnt_q, cur_idx;  // cnt_q is index of next word
  logic [2:0]                 hdr_cnt_q, hdr_cnt_nxt;
  logic [1:0]                 vlan_cnt_q, vlan_cnt_nxt;
  logic                       is_tpid;
  logic [`RXP_DATA_W-1:0]     data_d1;
  logic                       valid_d1, sop_d1, eop_d1;

  assign is_tpid = int_data[31:16] == rx_parser_pkg::ET_VLAN_1 ||
                   int_data[31:16] == rx_parser_pkg::ET_VLAN_2 ||
                   int_data[31:16] == rx_parser_pkg::ET_VLAN_3;

  always_comb begin
    cur_state = int_sop ? rx_parser_pkg::ST_PRE : state_q;
    cur_idx = int_sop ? '0 : cnt_q;
    // ipv4 needs the type and a version nibble of 4 in the same word
    if (int_data[31:16] == rx_parser_pkg::ET_IPV4 && int_data[15:12] == 4'h4)
      l3_state = rx_parser_pkg::ST_IPV4;
    else
      l3_state = rx_parser_pkg::ST_PAYLOAD;
    state_nxt = cur_state;
    vlan_cnt_nxt = vlan_cnt_q;
    proto_nxt = proto_q;
    tag = '0;
    case (cur_state)
      rx_parser_pkg::ST_PRE: begin
        vlan_cnt_nxt = '0;
        proto_nxt = rx_parser_pkg::ip_proto_e'(8'h00);
        if (cur_idx == 1)
          state_nxt = rx_parser_pkg::ST_MAC;  // sfd word
      end
      rx_parser_pkg::ST_MAC: begin
        if (cur_idx == `RXP_TYPE_WORD && is_tpid) begin
          tag.vlan = 1'b1;
          vlan_cnt_nxt = 2'd1;
          state_nxt = rx_parser_pkg::ST_VLAN;
        end else begin
          tag.mac = 1'b1;
          if (cur_idx == `RXP_TYPE_WORD)
            state_nxt = l3_state;
        end
      end
      rx_parser_pkg::ST_VLAN: begin
        tag.vlan = 1'b1;
        if (is_tpid && vlan_cnt_q < `RXP_MAX_VLAN)
          vlan_cnt_nxt = vlan_cnt_q + 2'd1;  // stacked tag
        else
          state_nxt = l3_state;
      end
      rx_parser_pkg::ST_IPV4: begin
        tag.ipv4 = 1'b1;
        if (hdr_cnt_q == 3'd1)
          proto_nxt = rx_parser_pkg::ip_proto_e'(int_data[7:0]);
        if (hdr_cnt_q == 3'(`RXP_IPV4_WORDS - 1)) begin
          case (proto_q)
            rx_parser_pkg::IP_UDP: state_nxt = rx_parser_pkg::ST_UDP;
            rx_parser_pkg::IP_TCP: state_nxt = rx_parser_pkg::ST_TCP;
            default:               state_nxt = rx_parser_pkg::ST_PAYLOAD;
          endcase
        end
      end
      rx_parser_pkg::ST_UDP: begin
        tag.l4 = 1'b1;
        if (hdr_cnt_q == 3'(`RXP_UDP_WORDS - 1))
          state_nxt = rx_parser_pkg::ST_PAYLOAD;
      end
      rx_parser_pkg::ST_TCP: begin
        tag.l4 = 1'b1;
        if (hdr_cnt_q == 3'(`RXP_TCP_WORDS - 1))
          state_nxt = rx_parser_pkg::ST_PAYLOAD;
      end
      rx_parser_pkg::ST_PAYLOAD: ;
      default: state_nxt = rx_parser_pkg::ST_PRE;
    endcase
    hdr_cnt_nxt = (state_nxt != cur_state) ? 3'd0 : hdr_cnt_q + 3'd1;
    if (int_eop)
      state_nxt = rx_parser_pkg::ST_PRE;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= rx_parser_pkg::ST_PRE;
      cnt_q      <= '0;
      hdr_cnt_q  <= '0;
      vlan_cnt_q <= '0;
      proto_q    <= rx_parser_pkg::ip_proto_e'(8'h00);
    end else if (par_en && int_valid) begin
      state_q    <= state_nxt;
      cnt_q      <= int_eop ? '0 : ((&cur_idx) ? cur_idx : cur_idx + 1'b1);
      hdr_cnt_q  <= hdr_cnt_nxt;
      vlan_cnt_q <= vlan_cnt_nxt;
      proto_q    <= proto_nxt;
    end
  end

  // stage 1, feeds the interface
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_d1 <= 1'b0;
      sop_d1   <= 1'b0;
      eop_d1   <= 1'b0;
      tag_d1   <= '0;
    end else if (par_en) begin
      valid_d1 <= int_valid;
      sop_d1   <= int_valid && int_sop;
      eop_d1   <= int_valid && int_eop;
      tag_d1   <= int_valid ? tag : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (par_en) begin
      data_d1 <= int_data;
      mod_d   <= int_mod;
    end
  end

  assign wrd.data  = data_d1;
  assign wrd.valid = valid_d1;
  assign wrd.sop   = sop_d1;
  assign wrd.eop   = eop_d1;
  assign wrd.tag   = tag_d1;

  // stage 2, output ports
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_sop   <= 1'b0;
      out_eop   <= 1'b0;
      out_info  <= '0;
    end else if (par_en) begin
      out_valid <= valid_d1;
      out_sop   <= sop_d1;
      out_eop   <= eop_d1;
      out_info  <= {{(`RXP_DATA_W - 4){1'b0}}, tag_d1};
    end
  end

  always_ff @(posedge clk) begin
    if (par_en) begin
      out_data <= data_d1;
      out_mod  <= mod_d;
    end
  end

  a_tag_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(tag_d1));

  // a frame never restarts or ends on its sfd word
  a_no_short_pre : assert property (@(posedge clk) disable iff (rst)
    (par_en && int_valid && state_q == rx_parser_pkg::ST_PRE && cnt_q == 1)
      |-> (!int_sop && !int_eop));

endmodule

`default_nettype wire

// ==== rtl/rx_field_extract.sv ====
// rx field extractor, captures mac addresses, ethertype, vlan count, ip protocol and length
`default_nettype none
`include "rx_parser_defs.svh"

module rx_field_extract (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         par_en,
  rx_word_if.snk                      wrd,
  input  wire [`RXP_MOD_W-1:0]        mod_d,
  output logic [47:0]                 mac_da,
  output logic [47:0]                 mac_sa,
  output rx_parser_pkg::eth_type_e    mac_type,
  output logic [1:0]                  vlan_num,
  output logic                        ipv4_seen,
  output rx_parser_pkg::ip_proto_e    ip_protocol,
  output logic [`RXP_LEN_W-1:0]       frame_len,
  output logic                        frame_done
);

  logic [2:0]             idx_q, cur_idx;  // saturates at the type word
  logic [2:0]             ip_cnt_q;
  logic                   l2_done_q;
  logic                   is_tpid, l2_word, l2_more;
  logic [`RXP_LEN_W-1:0]  word_bytes;

  assign cur_idx = wrd.sop ? 3'd0 : idx_q;

  assign is_tpid = wrd.data[31:16] == rx_parser_pkg::ET_VLAN_1 ||
                   wrd.data[31:16] == rx_parser_pkg::ET_VLAN_2 ||
                   wrd.data[31:16] == rx_parser_pkg::ET_VLAN_3;

  // l2 word from the type position on, until the final ethertype
  assign l2_word = cur_idx == 3'(`RXP_TYPE_WORD) && !l2_done_q &&
                   (wrd.tag.mac || wrd.tag.vlan);
  assign l2_more = is_tpid && vlan_num < `RXP_MAX_VLAN;

  assign ipv4_seen = ip_cnt_q != 3'd0;

  always_comb begin
    word_bytes = 'd4;
    if (wrd.eop && mod_d != '0)
      word_bytes = {{(`RXP_LEN_W - `RXP_MOD_W){1'b0}}, mod_d};  // mod 0 is a full word
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      idx_q      <= '0;
      ip_cnt_q   <= '0;
      l2_done_q  <= 1'b0;
      vlan_num   <= '0;
      frame_done <= 1'b0;
    end else if (par_en) begin
      frame_done <= wrd.valid && wrd.eop;
      if (wrd.valid) begin
        idx_q <= (cur_idx == 3'(`RXP_TYPE_WORD)) ? cur_idx : cur_idx + 3'd1;
        if (wrd.sop) begin
          ip_cnt_q  <= '0;
          l2_done_q <= 1'b0;
          vlan_num  <= '0;
        end else begin
          if (l2_word && l2_more)
            vlan_num <= vlan_num + 2'd1;
          if (l2_word && !l2_more)
            l2_done_q <= 1'b1;
          if (wrd.tag.ipv4 && ip_cnt_q != 3'd7)
            ip_cnt_q <= ip_cnt_q + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (par_en && wrd.valid) begin
      if (wrd.sop) begin
        mac_da      <= '0;
        mac_sa      <= '0;
        mac_type    <= rx_parser_pkg::eth_type_e'(16'h0000);
        ip_protocol <= rx_parser_pkg::ip_proto_e'(8'h00);
        frame_len   <= '0;
      end else begin
        case (cur_idx)
          3'd2: mac_da[47:16] <= wrd.data;
          3'd3: begin
            mac_da[15:0]  <= wrd.data[31:16];
            mac_sa[47:32] <= wrd.data[15:0];
          end
          3'd4: mac_sa[31:0] <= wrd.data;
          default: ;
        endcase
        if (cur_idx >= 3'd2)
          frame_len <= frame_len + word_bytes;  // bytes after preamble
        if (l2_word && !l2_more)
          mac_type <= rx_parser_pkg::eth_type_e'(wrd.data[31:16]);
        if (wrd.tag.ipv4 && ip_cnt_q == 3'd1)
          ip_protocol <= rx_parser_pkg::ip_proto_e'(wrd.data[7:0]);  // byte 9 of ip header
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rx_frame_stat.sv ====
// rx frame statistics, decodes captured fields into the stat vector at frame end
`default_nettype none
`include "rx_parser_defs.svh"

module rx_frame_stat (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          par_en,
  input  wire [47:0]                   mac_da,
  input  wire [47:0]                   mac_sa,
  input  rx_parser_pkg::eth_type_e     mac_type,
  input  wire [1:0]                    vlan_num,
  input  wire                          ipv4_seen,
  input  rx_parser_pkg::ip_proto_e     ip_protocol,
  input  wire [`RXP_LEN_W-1:0]         frame_len,
  input  wire                          frame_done,
  output logic                         stat_chk,
  output logic [`RXP_STAT_W-1:0]       out_stat
);

  logic                    bcast, mcast;
  logic [`RXP_STAT_W-1:0]  stat_d;

  assign bcast = &mac_da;
  assign mcast = mac_da[40] && !bcast;  // i/g bit of first da byte

  always_comb begin
    stat_d = '0;
    stat_d[rx_parser_pkg::SB_BCAST]     = bcast;
    stat_d[rx_parser_pkg::SB_MCAST]     = mcast;
    stat_d[rx_parser_pkg::SB_UCAST]     = !bcast && !mcast;
    stat_d[rx_parser_pkg::SB_KEEPALIVE] = mac_da == mac_sa;
    stat_d[rx_parser_pkg::SB_ARP]       = mac_type == rx_parser_pkg::ET_ARP;
    stat_d[rx_parser_pkg::SB_PAUSE]     = mac_type == rx_parser_pkg::ET_PAUSE;
    stat_d[rx_parser_pkg::SB_VLAN1]     = vlan_num == 2'd1;
    stat_d[rx_parser_pkg::SB_VLAN2]     = vlan_num == 2'd2;
    stat_d[rx_parser_pkg::SB_IPV4]      = ipv4_seen;
    stat_d[rx_parser_pkg::SB_TCP]       = ipv4_seen && ip_protocol == rx_parser_pkg::IP_TCP;
    stat_d[rx_parser_pkg::SB_UDP]       = ipv4_seen && ip_protocol == rx_parser_pkg::IP_UDP;
    stat_d[rx_parser_pkg::SB_ANY]       = 1'b1;
    stat_d[rx_parser_pkg::SB_RUNT]      = frame_len < `RXP_RUNT_LEN;
    stat_d[rx_parser_pkg::SB_JUMBO]     = frame_len > `RXP_JUMBO_LEN;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stat_chk <= 1'b0;
      out_stat <= '0;
    end else if (par_en) begin
      stat_chk <= frame_done;
      if (frame_done)
        out_stat <= stat_d;  // held until next frame end
    end
  end

  // frame_done is a single enabled-cycle pulse from the extractor
  a_chk_single : assert property (@(posedge clk) disable iff (rst)
    (par_en && stat_chk) |-> !frame_done);

endmodule

`default_nettype wire

// ==== rtl/rx_parser.sv ====
// rx ethernet frame parser top, stream pass-through with layer tags and frame statistics
`default_nettype none
`include "rx_parser_defs.svh"

module rx_parser (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        par_en,   // global stall while low
  input  wire [`RXP_DATA_W-1:0]      int_data,
  input  wire                        int_valid,
  input  wire                        int_sop,
  input  wire                        int_eop,
  input  wire [`RXP_MOD_W-1:0]       int_mod,
  output wire [`RXP_DATA_W-1:0]      out_data,
  output wire                        out_valid,
  output wire                        out_sop,
  output wire                        out_eop,
  output wire [`RXP_MOD_W-1:0]       out_mod,
  output wire [`RXP_DATA_W-1:0]      out_info,
  output wire                        stat_chk,
  output wire [`RXP_STAT_W-1:0]      out_stat
);

  rx_word_if wrd ();

  logic [`RXP_MOD_W-1:0]     mod_d;
  logic [47:0]               mac_da;
  logic [47:0]               mac_sa;
  rx_parser_pkg::eth_type_e  mac_type;
  logic [1:0]                vlan_num;
  logic                      ipv4_seen;
  rx_parser_pkg::ip_proto_e  ip_protocol;
  logic [`RXP_LEN_W-1:0]     frame_len;
  logic                      frame_done;

  rx_header_walker u_walker (
    .clk       (clk),
    .rst       (rst),
    .par_en    (par_en),
    .int_data  (int_data),
    .int_valid (int_valid),
    .int_sop   (int_sop),
    .int_eop   (int_eop),
    .int_mod   (int_mod),
    .wrd       (wrd.src),
    .mod_d     (mod_d),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_sop   (out_sop),
    .out_eop   (out_eop),
    .out_mod   (out_mod),
    .out_info  (out_info)
  );

  rx_field_extract u_extract (
    .clk         (clk),
    .rst         (rst),
    .par_en      (par_en),
    .wrd         (wrd.snk),
    .mod_d       (mod_d),
    .mac_da      (mac_da),
    .mac_sa      (mac_sa),
    .mac_type    (mac_type),
    .vlan_num    (vlan_num),
    .ipv4_seen   (ipv4_seen),
    .ip_protocol (ip_protocol),
    .frame_len   (frame_len),
    .frame_done  (frame_done)
  );

  rx_frame_stat u_stat (
    .clk         (clk),
    .rst         (rst),
    .par_en      (par_en),
    .mac_da      (mac_da),
    .mac_sa      (mac_sa),
    .mac_type    (mac_type),
    .vlan_num    (vlan_num),
    .ipv4_seen   (ipv4_seen),
    .ip_protocol (ip_protocol),
    .frame_len   (frame_len),
    .frame_done  (frame_done),
    .stat_chk    (stat_chk),
    .out_stat    (out_stat)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_rx_model_pkg.sv ====
// rx parser reference model with lfsr source, frame builder, expected layer tags and stats
`default_nettype none
`include "rx_parser_defs.svh"

package tb_rx_model_pkg;

  logic [15:0] lfsr = 16'd30026;

  // last built frame, preamble and sfd included
  logic [`RXP_DATA_W-1:0]    frm_data[$];
  rx_parser_pkg::layer_tag_t frm_tag[$];
  logic [`RXP_MOD_W-1:0]     frm_mod;
  logic [`RXP_STAT_W-1:0]    frm_stat;

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // t is the word holding the final ethertype
  function automatic rx_parser_pkg::layer_tag_t tag_of_word(input int idx, t,
                                                          input logic ipv4, input int l4n);
    rx_parser_pkg::layer_tag_t tag;
    tag = '0;
    if (idx >= 2 && idx <= 4)
      tag.mac = 1'b1;
    else if (idx == `RXP_TYPE_WORD && t == idx)
      tag.mac = 1'b1;  // untagged type word
    else if (idx >= `RXP_TYPE_WORD && idx <= t)
      tag.vlan = 1'b1;
    else if (ipv4 && idx > t && idx <= t + `RXP_IPV4_WORDS)
      tag.ipv4 = 1'b1;
    else if (ipv4 && idx > t + `RXP_IPV4_WORDS && idx <= t + `RXP_IPV4_WORDS + l4n)
      tag.l4 = 1'b1;
    return tag;
  endfunction

  function automatic void build_frame();
    logic [31:0] r;
    logic [47:0] da, sa;
    logic [15:0] etype;
    logic [7:0]  proto;
    logic        ipv4;
    int          nvlan, t, l4n, hend, nwords, len;
    frm_data.delete();
    frm_tag.delete();
    r = next_bits(16);
    sa = {r[15:0], next_bits(32)};
    r = next_bits(16);
    da = {r[15:0], next_bits(32)};
    case (next_bits(2))
      0: da = '1;
      1: da[40] = 1'b1;  // group address
      2: da[40] = 1'b0;
      default: da = sa;
    endcase
    nvlan = int'(next_bits(2) % 3);
    t = `RXP_TYPE_WORD + nvlan;
    r = next_bits(3);
    if (r < 4)
      etype = 16'h0800;
    else if (r == 4)
      etype = 16'h0806;
    else if (r == 5)
      etype = 16'h8808;
    else
      etype = 16'h88b5;
    ipv4 = etype == 16'h0800;
    r = next_bits(2);
    proto = (r == 0) ? 8'd6 : (r == 1) ? 8'd17 : 8'd1;
    if (!ipv4)
      l4n = 0;
    else
      l4n = (proto == 8'd6) ? `RXP_TCP_WORDS : (proto == 8'd17) ? `RXP_UDP_WORDS : 0;
    hend = ipv4 ? t + `RXP_IPV4_WORDS + l4n : t;
    if (next_bits(4) == 0)
      nwords = hend + 381 + int'(next_bits(4));  // jumbo
    else
      nwords = hend + 1 + int'(next_bits(3));
    r = next_bits(2);
    frm_mod = r[1:0];
    len = (nwords - 3) * 4 + ((frm_mod == 0) ? 4 : int'(frm_mod));

    for (int i = 0; i < nwords; i++) begin
      r = next_bits(32);
      if (i == 0)
        r = 32'h5555_5555;
      else if (i == 1)
        r = 32'h5555_55d5;  // sfd
      else if (i == 2)
        r = da[47:16];
      else if (i == 3)
        r = {da[15:0], sa[47:32]};
      else if (i == 4)
        r = sa[31:0];
      else if (i < t) begin
        case (next_bits(2))
          0: r[31:16] = 16'h8100;
          1: r[31:16] = 16'h88a8;
          default: r[31:16] = 16'h9100;
        endcase
      end else if (i == t)
        r = {etype, ipv4 ? {8'h45, r[7:0]} : r[15:0]};
      else if (ipv4 && i == t + 2)
        r[7:0] = proto;
      frm_data.push_back(r);
      frm_tag.push_back(tag_of_word(i, t, ipv4, l4n));
    end

    frm_stat = '0;
    frm_stat[0] = &da;
    frm_stat[1] = da[40] && !(&da);
    frm_stat[2] = !frm_stat[0] && !frm_stat[1];
    frm_stat[3] = da == sa;
    frm_stat[8] = etype == 16'h0806;
    frm_stat[9] = etype == 16'h8808;
    frm_stat[16] = nvlan == 1;
    frm_stat[17] = nvlan == 2;
    frm_stat[32] = ipv4;
    frm_stat[40] = ipv4 && proto == 8'd6;
    frm_stat[41] = ipv4 && proto == 8'd17;
    frm_stat[56] = 1'b1;
    frm_stat[57] = len < `RXP_RUNT_LEN;
    frm_stat[58] = len > `RXP_JUMBO_LEN;
  endfunction

endpackage

`default_nettype wire

// ==== testbench/tb_rx_parser.sv ====
// rx parser testbench, random frames with stalls checked against the reference model
`default_nettype none
`include "rx_parser_defs.svh"

module tb_rx_parser;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FRAMES = 48;

  typedef struct packed {
    logic                   valid;
    logic                   sop;
    logic                   eop;
    logic [`RXP_MOD_W-1:0]  mod;
    logic [`RXP_DATA_W-1:0] data;
  } beat_t;

  logic                      clk, rst, par_en;
  logic [`RXP_DATA_W-1:0]    int_data;
  logic                      int_valid, int_sop, int_eop;
  logic [`RXP_MOD_W-1:0]     int_mod;
  logic [`RXP_DATA_W-1:0]    out_data, out_info;
  logic                      out_valid, out_sop, out_eop, stat_chk;
  logic [`RXP_MOD_W-1:0]     out_mod;
  logic [`RXP_STAT_W-1:0]    out_stat;

  beat_t                     stim[$];
  beat_t                     exp_word[$];
  rx_parser_pkg::layer_tag_t exp_tag[$];
  logic [`RXP_STAT_W-1:0]    exp_stat[$];
  int                        acc_q[$];   // enabled-edge index of each accepted word
  int                        eop_q[$];
  beat_t                     b, want;
  logic                      edge_en = 1'b0;
  int                        en_cyc = 0;
  int                        limit = 0;
  int                        cycles = 0;
  int                        frames_out = 0;
  int                        gaps, last;
  string                     name;

  rx_parser DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string tname, input logic [31:0] e_data,
                            input logic e_sop, e_eop, input logic [1:0] e_mod,
                            input logic [31:0] a_data, input logic a_sop, a_eop,
                            input logic [1:0] a_mod);
    if (e_data !== a_data || e_sop !== a_sop || e_eop !== a_eop || e_mod !== a_mod) begin
      $display("[ERROR] %s: expected data %h sop %b eop %b mod %0d", tname, e_data, e_sop,
               e_eop, e_mod);
      $display("[ERROR] %s: actual data %h sop %b eop %b mod %0d", tname, a_data, a_sop,
               a_eop, a_mod);
      abort_run();
    end
  endtask

  task automatic check_tag(input string tname, input rx_parser_pkg::layer_tag_t e_tag,
                           input rx_parser_pkg::layer_tag_t a_tag);
    if (e_tag !== a_tag) begin
      $display("[ERROR] %s: expected tag %b, actual tag %b", tname, e_tag, a_tag);
      abort_run();
    end
  endtask

  task automatic check_stat(input string tname, input logic [`RXP_STAT_W-1:0] e_stat,
                            input logic [`RXP_STAT_W-1:0] a_stat);
    if (e_stat !== a_stat) begin
      $display("[ERROR] %s: expected stat %h, actual stat %h", tname, e_stat, a_stat);
      abort_run();
    end
  endtask

  task automatic check_latency(input string tname, input int e_edge, input int a_edge);
    if (e_edge != a_edge) begin
      $display("[ERROR] %s: expected enabled edge %0d, actual %0d", tname, e_edge, a_edge);
      abort_run();
    end
  endtask

  // holds the beat until an enabled edge takes it
  task automatic send_beat(input beat_t beat);
    @(negedge clk);
    {int_valid, int_sop, int_eop, int_mod, int_data} = beat;
    par_en = tb_rx_model_pkg::next_bits(3) != 0;
    while (!par_en) begin
      @(negedge clk);
      par_en = tb_rx_model_pkg::next_bits(3) != 0;
    end
  endtask

  initial begin
    rst = 1'b1;
    par_en = 1'b0;
    {int_valid, int_sop, int_eop, int_mod, int_data} = '0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      tb_rx_model_pkg::build_frame();
      last = tb_rx_model_pkg::frm_data.size() - 1;
      for (int i = 0; i <= last; i++) begin
        b.valid = 1'b1;
        b.sop = i == 0;
        b.eop = i == last;
        b.mod = (i == last) ? tb_rx_model_pkg::frm_mod : '0;
        b.data = tb_rx_model_pkg::frm_data[i];
        stim.push_back(b);
        exp_word.push_back(b);
        exp_tag.push_back(tb_rx_model_pkg::frm_tag[i]);
      end
      exp_stat.push_back(tb_rx_model_pkg::frm_stat);
      gaps = int'(tb_rx_model_pkg::next_bits(2));
      repeat (gaps) stim.push_back('0);
    end
    limit = stim.size() * 2 + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (stim.size() != 0)
      send_beat(stim.pop_front());
    @(negedge clk);
    int_valid = 1'b0;
    par_en = 1'b1;
    while (exp_word.size() != 0 || exp_stat.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);  // catch late extra outputs
    $display("TEST OK");
    $finish;
  end

  always @(posedge clk) begin
    edge_en = par_en && !rst;
    if (edge_en) begin
      en_cyc = en_cyc + 1;
      if (int_valid)
        acc_q.push_back(en_cyc);
      if (int_valid && int_eop)
        eop_q.push_back(en_cyc);
    end
  end

  // outputs are settled here, a downstream register takes them on the next enabled edge
  always @(negedge clk) begin
    if (!rst && edge_en) begin
      if (out_valid) begin
        if (exp_word.size() == 0) begin
          $display("output word seen with no input word left to match it");
          abort_run();
        end
        name = $sformatf("pass-through frame %0d", frames_out);
        want = exp_word.pop_front();
        check_word(name, want.data, want.sop, want.eop, want.mod, out_data, out_sop,
                   out_eop, out_mod);
        check_latency({name, " latency"}, acc_q.pop_front() + 2, en_cyc + 1);
        check_tag($sformatf("layer tag frame %0d", frames_out), exp_tag.pop_front(),
                  rx_parser_pkg::layer_tag_t'(out_info[3:0]));
        if (out_info[31:4] != '0) begin
          $display("out_info has bits set above the layer tag");
          abort_run();
        end
        if (out_eop)
          frames_out = frames_out + 1;
      end
      if (stat_chk) begin
        if (exp_stat.size() == 0 || eop_q.size() == 0) begin
          $display("stat_chk pulsed with no frame end pending");
          abort_run();
        end
        name = $sformatf("frame stat %0d", NUM_FRAMES - exp_stat.size());
        check_stat(name, exp_stat.pop_front(), out_stat);
        check_latency({name, " latency"}, eop_q.pop_front() + 3, en_cyc + 1);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: run still busy after %0d cycles", limit);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
rtl/rx_parser_pkg.sv
rtl/rx_word_if.sv
rtl/rx_header_walker.sv
rtl/rx_field_extract.sv
rtl/rx_frame_stat.sv
rtl/rx_parser.sv
testbench/tb_rx_model_pkg.sv
testbench/tb_rx_parser.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rx parser testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -j 0 -f verilog.f \
  --top-module tb_rx_parser -o sim_rx_parser
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_rx_parser > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
